// File: verilog.f
hw/calc_pkg.sv
hw/signmag_addsub.sv
hw/seq_multiplier.sv
hw/entry_controller.sv
hw/calc_top.sv
sim/clk_gen.sv
sim/calc_checker.sv
sim/calc_assertions.sv
sim/calc_tb.sv

// File: Bender.yml
package:
  name: calc_core

sources:
  - files:
      - hw/calc_pkg.sv
      - hw/signmag_addsub.sv
      - hw/seq_multiplier.sv
      - hw/entry_controller.sv
      - hw/calc_top.sv
  - target: test
    files:
      - sim/clk_gen.sv
      - sim/calc_checker.sv
      - sim/calc_assertions.sv
      - sim/calc_tb.sv

// File: sim/calc_tb.sv
// Keypad calculator testbench
`timescale 1ns/1ps

module calc_tb import calc_pkg::*; ();

    localparam int     DATA_W         = DATA_W_DEFAULT;
    localparam int     KEY_TIMEOUT    = 8;
    localparam int     RESULT_TIMEOUT = 4 * DATA_W;
    localparam longint MAG_MASK       = (64'd1 << (DATA_W - 1)) - 1;

    logic              clk;
    logic              nRST;
    logic              digit_valid;
    logic [3:0]        digit;
    logic              op_valid;
    op_t               op;
    logic              equal_valid;
    logic              key_read;
    logic              complete;
    logic [DATA_W-1:0] result;

    // Model copies of the operands being entered
    logic [DATA_W-1:0] opnd_a;
    logic [DATA_W-1:0] opnd_b;
    int                seed;

    clk_gen #(.PERIOD(8), .RESET_CYCLES(8)) clk_gen_inst (.clk(clk), .nRST(nRST));

    calc_top #(.DATA_W(DATA_W)) calc_top_inst (
        .clk         (clk),
        .nRST        (nRST),
        .digit_valid (digit_valid),
        .digit       (digit),
        .op_valid    (op_valid),
        .op          (op),
        .equal_valid (equal_valid),
        .key_read    (key_read),
        .complete    (complete),
        .result      (result)
    );

    calc_checker #(.DATA_W(DATA_W)) calc_checker_inst (
        .clk      (clk),
        .nRST     (nRST),
        .key_read (key_read),
        .complete (complete),
        .result   (result)
    );

    // Times ten plus digit with the sign kept
    function automatic logic [DATA_W-1:0] shift_in_digit(input logic [DATA_W-1:0] val,
                                                         input logic [3:0] d);
        longint mag;
        mag = val[DATA_W-2:0];
        mag = (mag * 10 + d) & MAG_MASK;
        return {val[DATA_W-1], mag[DATA_W-2:0]};
    endfunction

    function automatic logic [DATA_W-1:0] calc_model(input logic [DATA_W-1:0] a,
                                                     input logic [DATA_W-1:0] b,
                                                     input op_t f);
        longint va;
        longint vb;
        longint res;
        longint mag;
        logic   neg;
        va = a[DATA_W-2:0];
        vb = b[DATA_W-2:0];
        if (a[DATA_W-1]) va = -va;
        if (b[DATA_W-1]) vb = -vb;
        case (f)
            OP_ADD:  res = va + vb;
            OP_SUB:  res = va - vb;
            default: res = va * vb;
        endcase
        neg = (res < 0);
        mag = (neg ? -res : res) & MAG_MASK;
        // Zero is always positive
        if (mag == 0) neg = 1'b0;
        return {neg, mag[DATA_W-2:0]};
    endfunction

    task automatic press_digit(input int which, input logic [3:0] d, input int dropped);
        int n;
        int i;
        @(posedge clk);
        #1;
        digit_valid = 1'b1;
        digit       = d;
        @(posedge clk);
        #1;
        digit_valid = 1'b0;
        calc_checker_inst.expect_key();
        n = 0;
        while (!key_read && n < KEY_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!key_read) begin
            calc_checker_inst.report_error($sformatf("no key_read for digit %0d", d));
        end
        if (which == 1) begin
            opnd_a = shift_in_digit(opnd_a, d);
        end else begin
            opnd_b = shift_in_digit(opnd_b, d);
        end
        // Back in a wait state DATA_W+2 cycles after the strobe
        for (i = 0; i < DATA_W + 2; i++) begin
            @(posedge clk);
            #1;
            if (i == 2 && dropped >= 0) begin
                digit_valid = 1'b1;
                digit       = 4'(dropped);
            end else begin
                digit_valid = 1'b0;
            end
        end
    endtask

    task automatic press_op(input op_t f);
        @(posedge clk);
        #1;
        op_valid = 1'b1;
        op       = f;
        @(posedge clk);
        #1;
        op_valid = 1'b0;
        op       = OP_NONE;
    endtask

    task automatic press_equal();
        @(posedge clk);
        #1;
        equal_valid = 1'b1;
        @(posedge clk);
        #1;
        equal_valid = 1'b0;
    endtask

    task automatic negate_operand(input int which);
        press_op(OP_NEG);
        if (which == 1) begin
            opnd_a[DATA_W-1] = ~opnd_a[DATA_W-1];
        end else begin
            opnd_b[DATA_W-1] = ~opnd_b[DATA_W-1];
        end
    endtask

    // Enter decimal digits most significant first
    task automatic enter_number(input int which, input int value);
        int digs[$];
        int v;
        v = value;
        do begin
            digs.push_front(v % 10);
            v = v / 10;
        end while (v > 0);
        foreach (digs[k]) begin
            press_digit(which, 4'(digs[k]), -1);
        end
    endtask

    task automatic run_op(input string name, input int a, input logic neg_a, input op_t f,
                          input int b, input logic neg_b);
        opnd_a = '0;
        opnd_b = '0;
        enter_number(1, a);
        if (neg_a) negate_operand(1);
        press_op(f);
        enter_number(2, b);
        if (neg_b) negate_operand(2);
        calc_checker_inst.expect_result(name, calc_model(opnd_a, opnd_b, f));
        press_equal();
        calc_checker_inst.wait_results(RESULT_TIMEOUT);
    endtask

    task automatic idle_cycles(input int cycles);
        int i;
        for (i = 0; i < cycles; i++) begin
            @(posedge clk);
        end
        #1;
    endtask

    initial begin : stimulus
        int   n;
        int   i;
        int   a;
        int   b;
        op_t  f;
        logic na;
        logic nb;
        digit_valid = 1'b0;
        digit       = 4'd0;
        op_valid    = 1'b0;
        op          = OP_NONE;
        equal_valid = 1'b0;
        opnd_a      = '0;
        opnd_b      = '0;
        seed        = 32'h1e8c_f24c;

        n = 0;
        while (!nRST && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!nRST) calc_checker_inst.report_error("reset was never released");
        #1;
        calc_checker_inst.check_idle("after reset");

        // No operator latched yet, so equals leaves the first operand alone
        opnd_a = '0;
        opnd_b = '0;
        press_digit(1, 4'd6, -1);
        press_equal();
        idle_cycles(DATA_W + 4);
        calc_checker_inst.check_idle("equals in WAIT_OP1");
        press_op(OP_ADD);
        press_digit(2, 4'd3, -1);
        calc_checker_inst.expect_result("equals ignored", calc_model(opnd_a, opnd_b, OP_ADD));
        press_equal();
        calc_checker_inst.wait_results(RESULT_TIMEOUT);

        run_op("add", 1234, 1'b0, OP_ADD, 567, 1'b0);
        run_op("sub", 5000, 1'b0, OP_SUB, 1234, 1'b0);
        run_op("sub negative", 25, 1'b0, OP_SUB, 300, 1'b0);
        run_op("mul mixed sign", 123, 1'b1, OP_MUL, 45, 1'b0);
        run_op("mul both negative", 12, 1'b1, OP_MUL, 34, 1'b1);
        run_op("mul zero", 77, 1'b1, OP_MUL, 0, 1'b0);
        run_op("six digit entry", 987654, 1'b0, OP_ADD, 0, 1'b0);

        // Digit 7 lands during the times-ten step and is lost
        opnd_a = '0;
        opnd_b = '0;
        press_digit(1, 4'd4, 7);
        press_digit(1, 4'd2, -1);
        press_op(OP_ADD);
        press_digit(2, 4'd5, -1);
        calc_checker_inst.expect_result("dropped digit", calc_model(opnd_a, opnd_b, OP_ADD));
        press_equal();
        calc_checker_inst.wait_results(RESULT_TIMEOUT);

        for (i = 0; i < 40; i++) begin
            a  = {$random(seed)} % 10000;
            b  = {$random(seed)} % 10000;
            na = {$random(seed)} % 2;
            nb = {$random(seed)} % 2;
            case ({$random(seed)} % 3)
                0:       f = OP_ADD;
                1:       f = OP_SUB;
                default: f = OP_MUL;
            endcase
            run_op($sformatf("random %0d", i), a, na, f, b, nb);
        end

        calc_checker_inst.check_keys();
        $display("Checked %0d results, %0d errors",
                 calc_checker_inst.result_count, calc_checker_inst.error_count);
        if (calc_checker_inst.error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim/calc_assertions.sv
// Controller strobe assertions
`timescale 1ns/1ps

module calc_assertions import calc_pkg::*; (
    input logic        clk,
    input logic        nRST,
    input logic        key_read,
    input logic        complete,
    input logic        add_start,
    input logic        mul_start,
    input ctrl_state_t state
);

    key_read_single: assert property (@(posedge clk) disable iff (!nRST)
        key_read |=> !key_read)
        else $error("key_read high for two cycles in a row");

    complete_single: assert property (@(posedge clk) disable iff (!nRST)
        complete |=> !complete)
        else $error("complete high for two cycles in a row");

    one_start: assert property (@(posedge clk) disable iff (!nRST)
        !(add_start && mul_start))
        else $error("add_start and mul_start high together");

    complete_after_show: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> $past(state) == SHOW_RESULT)
        else $error("complete without SHOW_RESULT the cycle before");

endmodule

bind entry_controller calc_assertions calc_assertions_inst (
    .clk       (clk),
    .nRST      (nRST),
    .key_read  (key_read),
    .complete  (complete),
    .add_start (add_start),
    .mul_start (mul_start),
    .state     (state)
);

// File: sim/calc_checker.sv
// Calculator result monitor
`timescale 1ns/1ps

module calc_checker import calc_pkg::*; #(
    parameter int DATA_W = DATA_W_DEFAULT
) (
    input logic              clk,
    input logic              nRST,
    input logic              key_read,
    input logic              complete,
    input logic [DATA_W-1:0] result
);

    int                error_count  = 0;
    int                result_count = 0;
    int                key_count    = 0;
    int                key_expected = 0;
    logic [DATA_W-1:0] exp_q[$];
    string             name_q[$];

    task automatic compare_value(input string name, input logic [DATA_W-1:0] exp,
                                 input logic [DATA_W-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            error_count++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        error_count++;
    endtask

    task automatic expect_result(input string name, input logic [DATA_W-1:0] value);
        exp_q.push_back(value);
        name_q.push_back(name);
    endtask

    task automatic expect_key();
        key_expected++;
    endtask

    // Wait until every queued result has come out
    task automatic wait_results(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp_q.size() != 0) begin
            report_error($sformatf("no complete for %s within %0d cycles",
                                   name_q[0], max_cycles));
            exp_q.delete();
            name_q.delete();
        end
    endtask

    task automatic check_idle(input string name);
        compare_value({name, " key_read"}, '0, DATA_W'(key_read));
        compare_value({name, " complete"}, '0, DATA_W'(complete));
        compare_value({name, " result"}, '0, result);
    endtask

    task automatic check_keys();
        compare_value("key_read count", DATA_W'(key_expected), DATA_W'(key_count));
    endtask

    always @(posedge clk) begin
        if (nRST && key_read) begin
            key_count++;
        end
        if (nRST && complete) begin
            if (exp_q.size() == 0) begin
                report_error($sformatf("complete pulsed with no result pending, result %h",
                                       result));
            end else begin
                compare_value(name_q.pop_front(), exp_q.pop_front(), result);
                result_count++;
            end
        end
    end

endmodule

// File: sim/clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic nRST
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Release just after an edge, like the stimulus
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        nRST = 1'b1;
    end

endmodule

// File: hw/calc_top.sv
// Keypad calculator core
`timescale 1ns/1ps

module calc_top import calc_pkg::*; #(
    parameter int DATA_W = DATA_W_DEFAULT
) (
    input  logic              clk,
    input  logic              nRST,
    input  logic              digit_valid,
    input  logic [3:0]        digit,
    input  logic              op_valid,
    input  op_t               op,
    input  logic              equal_valid,
    output logic              key_read,
    output logic              complete,
    output logic [DATA_W-1:0] result
);

    logic              add_start;
    logic              add_sub;
    logic [DATA_W-1:0] add_a;
    logic [DATA_W-1:0] add_b;
    logic              add_done;
    logic [DATA_W-1:0] add_sum;

    logic              mul_start;
    logic [DATA_W-1:0] mul_a;
    logic [DATA_W-1:0] mul_b;
    logic              mul_done;
    logic [DATA_W-1:0] mul_prod;

    entry_controller #(.DATA_W(DATA_W)) entry_controller_inst (
        .clk         (clk),
        .nRST        (nRST),
        .digit_valid (digit_valid),
        .digit       (digit),
        .op_valid    (op_valid),
        .op          (op),
        .equal_valid (equal_valid),
        .key_read    (key_read),
        .complete    (complete),
        .result      (result),
        .add_start   (add_start),
        .add_sub     (add_sub),
        .add_a       (add_a),
        .add_b       (add_b),
        .add_done    (add_done),
        .add_sum     (add_sum),
        .mul_start   (mul_start),
        .mul_a       (mul_a),
        .mul_b       (mul_b),
        .mul_done    (mul_done),
        .mul_prod    (mul_prod)
    );

    signmag_addsub #(.DATA_W(DATA_W)) signmag_addsub_inst (
        .clk   (clk),
        .nRST  (nRST),
        .start (add_start),
        .sub   (add_sub),
        .a     (add_a),
        .b     (add_b),
        .done  (add_done),
        .sum   (add_sum)
    );

    // Shared by digit entry and the multiply operator
    seq_multiplier #(.DATA_W(DATA_W)) seq_multiplier_inst (
        .clk   (clk),
        .nRST  (nRST),
        .start (mul_start),
        .a     (mul_a),
        .b     (mul_b),
        .done  (mul_done),
        .prod  (mul_prod)
    );

endmodule

// File: hw/entry_controller.sv
// Calculator entry and dispatch FSM
`timescale 1ns/1ps

module entry_controller import calc_pkg::*; #(
    parameter int DATA_W = DATA_W_DEFAULT
) (
    input  logic              clk,
    input  logic              nRST,

    input  logic              digit_valid,
    input  logic [3:0]        digit,
    input  logic              op_valid,
    input  op_t               op,
    input  logic              equal_valid,

    output logic              key_read,
    output logic              complete,
    output logic [DATA_W-1:0] result,

    output logic              add_start,
    output logic              add_sub,
    output logic [DATA_W-1:0] add_a,
    output logic [DATA_W-1:0] add_b,
    input  logic              add_done,
    input  logic [DATA_W-1:0] add_sum,

    output logic              mul_start,
    output logic [DATA_W-1:0] mul_a,
    output logic [DATA_W-1:0] mul_b,
    input  logic              mul_done,
    input  logic [DATA_W-1:0] mul_prod
);

    localparam int MAG_W = DATA_W - 1;

    ctrl_state_t       state;
    ctrl_state_t       next_state;
    logic [DATA_W-1:0] operand1;
    logic [DATA_W-1:0] operand2;
    logic [3:0]        digit_q;
    op_t               op_q;
    logic              in_wait;
    logic              is_arith;

    // Magnitude plus digit, wraps in the magnitude field
    function automatic logic [DATA_W-1:0] add_digit(
        input logic [DATA_W-1:0] val,
        input logic [3:0]        d
    );
        logic [MAG_W-1:0] mag;
        mag = val[MAG_W-1:0] + MAG_W'(d);
        return {val[DATA_W-1], mag};
    endfunction

    assign in_wait  = (state == WAIT_OP1) || (state == WAIT_OP2);
    assign is_arith = (op == OP_ADD) || (op == OP_SUB) || (op == OP_MUL);

    always_comb begin
        next_state = state;
        case (state)
            WAIT_OP1: begin
                if (digit_valid) begin
                    next_state = MUL10_OP1;
                end else if (op_valid && is_arith) begin
                    next_state = WAIT_OP2;
                end
            end
            MUL10_OP1: begin
                if (mul_done) begin
                    next_state = ADD_DIGIT_OP1;
                end
            end
            ADD_DIGIT_OP1: next_state = WAIT_OP1;
            WAIT_OP2: begin
                if (digit_valid) begin
                    next_state = MUL10_OP2;
                end else if (equal_valid) begin
                    next_state = DISPATCH;
                end
            end
            MUL10_OP2: begin
                if (mul_done) begin
                    next_state = ADD_DIGIT_OP2;
                end
            end
            ADD_DIGIT_OP2: next_state = WAIT_OP2;
            DISPATCH:      next_state = WAIT_RESULT;
            WAIT_RESULT: begin
                if (add_done || mul_done) begin
                    next_state = SHOW_RESULT;
                end
            end
            SHOW_RESULT:   next_state = WAIT_OP1;
            default:       next_state = WAIT_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state    <= WAIT_OP1;
            operand1 <= '0;
            operand2 <= '0;
            op_q     <= OP_NONE;
            key_read <= 1'b0;
            complete <= 1'b0;
            result   <= '0;
        end else begin
            state    <= next_state;
            key_read <= 1'b0;
            complete <= 1'b0;
            case (state)
                WAIT_OP1: begin
                    if (digit_valid) begin
                        key_read <= 1'b1;
                    end else if (op_valid && op == OP_NEG) begin
                        operand1[DATA_W-1] <= ~operand1[DATA_W-1];
                    end else if (op_valid && is_arith) begin
                        op_q <= op;
                    end
                end
                MUL10_OP1: begin
                    // Times ten keeps the operand's own sign
                    if (mul_done) begin
                        operand1 <= {operand1[DATA_W-1], mul_prod[MAG_W-1:0]};
                    end
                end
                ADD_DIGIT_OP1: operand1 <= add_digit(operand1, digit_q);
                WAIT_OP2: begin
                    if (digit_valid) begin
                        key_read <= 1'b1;
                    end else if (op_valid && op == OP_NEG) begin
                        operand2[DATA_W-1] <= ~operand2[DATA_W-1];
                    end
                end
                MUL10_OP2: begin
                    if (mul_done) begin
                        operand2 <= {operand2[DATA_W-1], mul_prod[MAG_W-1:0]};
                    end
                end
                ADD_DIGIT_OP2: operand2 <= add_digit(operand2, digit_q);
                WAIT_RESULT: begin
                    if (add_done) begin
                        result <= add_sum;
                    end else if (mul_done) begin
                        result <= mul_prod;
                    end
                end
                SHOW_RESULT: begin
                    complete <= 1'b1;
                    operand1 <= '0;
                    operand2 <= '0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_wait && digit_valid) begin
            digit_q <= digit;
        end
    end

    // key_read marks the first cycle of a times-ten step
    assign add_start = (state == DISPATCH) && (op_q != OP_MUL);
    assign mul_start = key_read || ((state == DISPATCH) && (op_q == OP_MUL));
    assign add_sub   = (op_q == OP_SUB);
    assign add_a     = operand1;
    assign add_b     = operand2;

    always_comb begin
        case (state)
            MUL10_OP1: begin
                mul_a = operand1;
                mul_b = DATA_W'(10);
            end
            MUL10_OP2: begin
                mul_a = operand2;
                mul_b = DATA_W'(10);
            end
            default: begin
                mul_a = operand1;
                mul_b = operand2;
            end
        endcase
    end

endmodule

// File: hw/seq_multiplier.sv
// Shift-and-add sign-magnitude multiplier
`timescale 1ns/1ps

module seq_multiplier import calc_pkg::*; #(
    parameter int DATA_W = DATA_W_DEFAULT
) (
    input  logic              clk,
    input  logic              nRST,
    input  logic              start,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    output logic              done,
    output logic [DATA_W-1:0] prod
);

    localparam int MAG_W = DATA_W - 1;
    localparam int CNT_W = $clog2(DATA_W);
    // One step per magnitude bit
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(MAG_W - 1);

    logic             busy;
    logic [CNT_W-1:0] count;
    logic             sign;
    logic [MAG_W-1:0] mcand;
    logic [MAG_W-1:0] mplier;
    logic [MAG_W-1:0] acc;
    logic [MAG_W-1:0] acc_next;

    // Add the shifted multiplicand when the current bit is set
    assign acc_next = mplier[0] ? acc + mcand : acc;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                count <= count + 1'b1;
                if (count == LAST_STEP) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (start) begin
                busy  <= 1'b1;
                count <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            if (count == LAST_STEP) begin
                // Low bits only, zero forced positive
                prod <= {sign & (|acc_next), acc_next};
            end
        end else if (start) begin
            mcand  <= a[MAG_W-1:0];
            mplier <= b[MAG_W-1:0];
            acc    <= '0;
            sign   <= a[DATA_W-1] ^ b[DATA_W-1];
        end
    end

endmodule

// File: hw/signmag_addsub.sv
// Sign-magnitude adder and subtractor
`timescale 1ns/1ps

module signmag_addsub import calc_pkg::*; #(
    parameter int DATA_W = DATA_W_DEFAULT
) (
    input  logic              clk,
    input  logic              nRST,
    input  logic              start,
    input  logic              sub,
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    output logic              done,
    output logic [DATA_W-1:0] sum
);

    localparam int MAG_W = DATA_W - 1;

    logic             a_sign;
    logic             b_sign;
    logic [MAG_W-1:0] a_mag;
    logic [MAG_W-1:0] b_mag;
    logic             res_sign;
    logic [MAG_W-1:0] res_mag;

    assign a_sign = a[DATA_W-1];
    // Subtraction is addition with b negated
    assign b_sign = b[DATA_W-1] ^ sub;
    assign a_mag  = a[MAG_W-1:0];
    assign b_mag  = b[MAG_W-1:0];

    always_comb begin
        if (a_sign == b_sign) begin
            res_mag  = a_mag + b_mag;
            res_sign = a_sign;
        end else if (a_mag >= b_mag) begin
            res_mag  = a_mag - b_mag;
            res_sign = a_sign;
        end else begin
            // Larger magnitude sets the sign
            res_mag  = b_mag - a_mag;
            res_sign = b_sign;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            // No negative zero
            sum <= {res_sign & (|res_mag), res_mag};
        end
    end

endmodule

// File: hw/calc_pkg.sv
// Calculator shared types
package calc_pkg;

    // Operand width, sign in the top bit
    parameter int DATA_W_DEFAULT = 16;

    // Operator codes as sent by the keypad
    typedef enum logic [2:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_t;

    // Entry and compute states
    typedef enum logic [3:0] {
        WAIT_OP1,
        MUL10_OP1,
        ADD_DIGIT_OP1,
        WAIT_OP2,
        MUL10_OP2,
        ADD_DIGIT_OP2,
        DISPATCH,
        WAIT_RESULT,
        SHOW_RESULT
    } ctrl_state_t;

endpackage
